//--- src/cache_defs.svh
// ================================================
// cache geometry and address split macros
// included by the packages and the cache RTL
// ================================================
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_ADDR_W   64                 // byte address
`define CACHE_WORD_W   64                 // cpu-side word
`define CACHE_LINE_W   512                // eight words per line
`define CACHE_LINES    8

// word select inside a line
`define CACHE_OFS_LSB  3
`define CACHE_OFS_MSB  5

// line index
`define CACHE_IDX_LSB  6
`define CACHE_IDX_MSB  8

`define CACHE_TAG_LSB  9                  // tag runs up to the address msb
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_TAG_LSB)

`endif

//--- src/cache_pkg.sv
// ================================================
// cache data types, memory opcodes, controller states
// ================================================
`include "cache_defs.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_WORD_W-1:0] word_t;
  typedef logic [`CACHE_LINE_W-1:0] line_t;
  typedef logic [`CACHE_TAG_W-1:0]  tag_t;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    C_IDLE, C_LOOKUP, C_FILL, C_UPDATE, C_WRITE_MEM, C_ACK
  } ctrl_state_e;

endpackage

//--- src/exer_pkg.sv
// ================================================
// exerciser states and the write pattern table
// ================================================
`include "cache_defs.svh"

package exer_pkg;

  typedef enum logic [2:0] {
    E_IDLE,
    E_GAP_W,    // idle gap before the write
    E_WRITE,
    E_GAP_R,    // idle gap before the read-back
    E_READ,
    E_DONE
  } exer_state_e;

  // word k uses entry k mod 8, xored with its byte address
  localparam logic [`CACHE_WORD_W-1:0] PATTERN [8] = '{
    64'h8c2078a7_07e5484d,
    64'h4765af4e_5226ec81,
    64'h8046a887_4f66de44,
    64'h24334404_8c940a7d,
    64'h01dec340_02e85dec,
    64'h9bb5df90_9d43c9b6,
    64'h2b9b566d_5c040a78,
    64'h196df530_aeb93dad
  };

endpackage

//--- src/cache_array.sv
// ================================================
// direct-mapped tag, valid and data store
// hit is combinational, fill and word write on the clock
// ================================================
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_array (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic [`CACHE_ADDR_W-1:0] i_addr,
  input  logic                     i_fill,
  input  logic [`CACHE_LINE_W-1:0] i_fill_line,
  input  logic                     i_wr,
  input  logic [`CACHE_WORD_W-1:0] i_wdata,
  output logic                     o_hit,
  output logic [`CACHE_WORD_W-1:0] o_rdata,
  output logic [`CACHE_LINE_W-1:0] o_line
);

  logic [`CACHE_LINES-1:0] valid_q;
  cache_pkg::tag_t         tag_q  [`CACHE_LINES];
  cache_pkg::line_t        data_q [`CACHE_LINES];

  logic [`CACHE_IDX_MSB-`CACHE_IDX_LSB:0] idx;
  logic [`CACHE_OFS_MSB-`CACHE_OFS_LSB:0] ofs;
  cache_pkg::tag_t                        tag;

  // address split
  assign idx = i_addr[`CACHE_IDX_MSB:`CACHE_IDX_LSB];
  assign ofs = i_addr[`CACHE_OFS_MSB:`CACHE_OFS_LSB];
  assign tag = i_addr[`CACHE_ADDR_W-1:`CACHE_TAG_LSB];

  assign o_hit   = valid_q[idx] && (tag_q[idx] == tag);
  assign o_line  = data_q[idx];                                   // write-through source
  assign o_rdata = o_line[ofs*`CACHE_WORD_W +: `CACHE_WORD_W];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= '0;
    end else if (i_fill) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // line and tag storage
  always_ff @(posedge i_clk) begin
    if (i_fill) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= i_fill_line;
    end else if (i_wr) begin
      // merge one word into the resident line
      data_q[idx][ofs*`CACHE_WORD_W +: `CACHE_WORD_W] <= i_wdata;
    end
  end

endmodule

//--- src/cache_ctrl_fsm.sv
// ================================================
// cache controller, lookup then fill and write-through
// acks the cpu side once per request
// ================================================
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_ctrl_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_req,
  input  cache_pkg::mem_op_e       i_op,
  input  logic [`CACHE_ADDR_W-1:0] i_addr,
  input  logic                     i_hit,
  input  logic [`CACHE_LINE_W-1:0] i_line,
  input  logic                     i_mem_ready,
  output logic                     o_ack,
  output logic                     o_fill,
  output logic                     o_wr,
  output logic                     o_mem_valid,
  output cache_pkg::mem_op_e       o_mem_op,
  output logic [`CACHE_ADDR_W-1:0] o_mem_addr,
  output logic [`CACHE_LINE_W-1:0] o_mem_wdata
);

  cache_pkg::ctrl_state_e state_q;
  cache_pkg::ctrl_state_e state_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= cache_pkg::C_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::C_IDLE: begin
        if (i_req) begin
          state_d = cache_pkg::C_LOOKUP;
        end
      end
      cache_pkg::C_LOOKUP: begin
        if (!i_hit) begin
          state_d = cache_pkg::C_FILL;     // allocate on read and write
        end else if (i_op == cache_pkg::MEM_WRITE) begin
          state_d = cache_pkg::C_UPDATE;
        end else begin
          state_d = cache_pkg::C_ACK;
        end
      end
      cache_pkg::C_FILL: begin
        if (i_mem_ready && i_op == cache_pkg::MEM_WRITE) begin
          state_d = cache_pkg::C_UPDATE;
        end else if (i_mem_ready) begin
          state_d = cache_pkg::C_ACK;
        end
      end
      cache_pkg::C_UPDATE:    state_d = cache_pkg::C_WRITE_MEM;
      cache_pkg::C_WRITE_MEM: begin
        if (i_mem_ready) begin
          state_d = cache_pkg::C_ACK;
        end
      end
      cache_pkg::C_ACK:       state_d = cache_pkg::C_IDLE;
      default:                state_d = cache_pkg::C_IDLE;
    endcase
  end

  assign o_ack  = (state_q == cache_pkg::C_ACK);
  assign o_fill = (state_q == cache_pkg::C_FILL) && i_mem_ready;  // line lands with ready
  assign o_wr   = (state_q == cache_pkg::C_UPDATE);

  // memory side held steady by state until ready
  assign o_mem_valid = (state_q == cache_pkg::C_FILL) || (state_q == cache_pkg::C_WRITE_MEM);
  assign o_mem_addr  = {i_addr[`CACHE_ADDR_W-1:`CACHE_IDX_LSB], {`CACHE_IDX_LSB{1'b0}}};
  assign o_mem_wdata = i_line;   // already holds the new word in C_WRITE_MEM

  always_comb begin
    if (state_q == cache_pkg::C_WRITE_MEM) begin
      o_mem_op = cache_pkg::MEM_WRITE;
    end else begin
      o_mem_op = cache_pkg::MEM_READ;
    end
  end

endmodule

//--- src/pace_timer.sv
// ================================================
// loadable gap counter, expired once it hits zero
// ================================================
`timescale 1ns/1ps

module pace_timer (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_load,
  input  logic [7:0] i_count,
  output logic       o_expired
);

  logic [7:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;                 // expired straight out of reset
    end else if (i_load) begin
      cnt_q <= i_count;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

  // stays set until the next load
  assign o_expired = (cnt_q == '0);

endmodule

//--- src/cache_exerciser.sv
// ================================================
// traffic exerciser: gap, write, gap, read-back per word
// counts read-back mismatches against the pattern rule
// ================================================
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_exerciser (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_start,
  input  logic [`CACHE_ADDR_W-1:0] i_base_addr,
  input  logic [7:0]               i_word_count,
  input  logic [7:0]               i_gap,
  input  logic                     i_expired,
  input  logic                     i_ack,
  input  logic [`CACHE_WORD_W-1:0] i_rdata,
  output logic                     o_load,
  output logic                     o_req,
  output cache_pkg::mem_op_e       o_op,
  output logic [`CACHE_ADDR_W-1:0] o_addr,
  output logic [`CACHE_WORD_W-1:0] o_wdata,
  output logic                     o_busy,
  output logic                     o_done,
  output logic [15:0]              o_mismatch_cnt
);

  exer_pkg::exer_state_e state_q;
  cache_pkg::addr_t      addr_q;
  cache_pkg::word_t      exp_word;
  logic [7:0]            word_idx_q;
  logic [15:0]           mismatch_q;
  logic                  load_q;
  logic                  last_word;
  logic                  gap_over;

  // same value is written and later expected back
  assign exp_word  = exer_pkg::PATTERN[word_idx_q[2:0]] ^ addr_q;
  assign last_word = (word_idx_q == i_word_count - 8'd1);

  // timer loads a cycle after the pulse, stale flag still right for a zero gap
  assign gap_over  = i_expired && (!load_q || i_gap == 8'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= exer_pkg::E_IDLE;
      addr_q     <= '0;
      word_idx_q <= '0;
      mismatch_q <= '0;
      load_q     <= 1'b0;
    end else begin
      load_q <= 1'b0;   // single-cycle pulse
      case (state_q)
        exer_pkg::E_IDLE, exer_pkg::E_DONE: begin
          if (i_start) begin
            addr_q     <= i_base_addr;
            word_idx_q <= '0;
            mismatch_q <= '0;
            if (i_word_count == '0) begin
              state_q <= exer_pkg::E_DONE;
            end else begin
              load_q  <= 1'b1;
              state_q <= exer_pkg::E_GAP_W;
            end
          end
        end
        exer_pkg::E_GAP_W: if (gap_over) state_q <= exer_pkg::E_WRITE;
        exer_pkg::E_WRITE: begin
          if (i_ack) begin
            load_q  <= 1'b1;
            state_q <= exer_pkg::E_GAP_R;
          end
        end
        exer_pkg::E_GAP_R: if (gap_over) state_q <= exer_pkg::E_READ;
        exer_pkg::E_READ: begin
          if (i_ack) begin
            if (i_rdata != exp_word) begin
              mismatch_q <= mismatch_q + 16'd1;
            end
            if (last_word) begin
              state_q <= exer_pkg::E_DONE;
            end else begin
              word_idx_q <= word_idx_q + 8'd1;
              addr_q     <= addr_q + `CACHE_ADDR_W'd8;    // next word
              load_q     <= 1'b1;
              state_q    <= exer_pkg::E_GAP_W;
            end
          end
        end
        default: state_q <= exer_pkg::E_IDLE;
      endcase
    end
  end

  assign o_load  = load_q;
  assign o_req   = (state_q == exer_pkg::E_WRITE) || (state_q == exer_pkg::E_READ);
  assign o_op    = (state_q == exer_pkg::E_WRITE) ? cache_pkg::MEM_WRITE : cache_pkg::MEM_READ;
  assign o_addr  = addr_q;
  assign o_wdata = exp_word;
  assign o_busy  = (state_q != exer_pkg::E_IDLE) && (state_q != exer_pkg::E_DONE);
  assign o_done  = (state_q == exer_pkg::E_DONE);
  assign o_mismatch_cnt = mismatch_q;

endmodule

//--- src/cache_sys_top.sv
// ================================================
// cache subsystem top: exerciser, controller, array, timer
// memory side is a line-wide valid/ready port
// ================================================
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_sys_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_start,
  input  logic [`CACHE_ADDR_W-1:0] i_base_addr,
  input  logic [7:0]               i_word_count,
  input  logic [7:0]               i_gap,
  output logic                     o_busy,
  output logic                     o_done,
  output logic [15:0]              o_mismatch_cnt,
  output logic                     o_mem_valid,
  output cache_pkg::mem_op_e       o_mem_op,
  output logic [`CACHE_ADDR_W-1:0] o_mem_addr,
  output logic [`CACHE_LINE_W-1:0] o_mem_wdata,
  input  logic [`CACHE_LINE_W-1:0] i_mem_rdata,
  input  logic                     i_mem_ready
);

  // cpu-side request
  logic                     req;
  cache_pkg::mem_op_e       op;
  logic [`CACHE_ADDR_W-1:0] addr;
  logic [`CACHE_WORD_W-1:0] wdata;
  logic [`CACHE_WORD_W-1:0] rdata;
  logic                     ack;

  logic                     load;
  logic                     expired;
  logic                     hit;
  logic                     fill;
  logic                     wr;
  logic [`CACHE_LINE_W-1:0] line;

  cache_exerciser u_exerciser (
    .clk(clk), .rst(rst),
    .i_start(i_start), .i_base_addr(i_base_addr), .i_word_count(i_word_count),
    .i_gap(i_gap), .i_expired(expired), .i_ack(ack), .i_rdata(rdata),
    .o_load(load), .o_req(req), .o_op(op), .o_addr(addr), .o_wdata(wdata),
    .o_busy(o_busy), .o_done(o_done), .o_mismatch_cnt(o_mismatch_cnt)
  );

  pace_timer u_timer (
    .clk(clk), .rst(rst), .i_load(load), .i_count(i_gap), .o_expired(expired)
  );

  cache_ctrl_fsm u_ctrl (
    .clk(clk), .rst(rst),
    .i_req(req), .i_op(op), .i_addr(addr), .i_hit(hit), .i_line(line),
    .i_mem_ready(i_mem_ready), .o_ack(ack), .o_fill(fill), .o_wr(wr),
    .o_mem_valid(o_mem_valid), .o_mem_op(o_mem_op), .o_mem_addr(o_mem_addr),
    .o_mem_wdata(o_mem_wdata)
  );

  cache_array u_array (
    .i_clk(clk), .i_rst(rst), .i_addr(addr),
    .i_fill(fill), .i_fill_line(i_mem_rdata),   // fill data straight from memory
    .i_wr(wr), .i_wdata(wdata),
    .o_hit(hit), .o_rdata(rdata), .o_line(line)
  );

endmodule

//--- verif/tb_clk_gen.sv
// ================================================
// free-running testbench clock, 100 ns period
// ================================================
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;   // half period
  end

endmodule

//--- verif/tb_cache_sys.sv
// ================================================
// cache subsystem testbench with a line memory model
// runs exerciser passes and checks memory against the pattern rule
// ================================================
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_cache_sys;

  localparam int DONE_LIMIT = 40000;   // cycles per exerciser run

  logic                     clk;
  logic                     rst;
  logic                     start;
  logic [`CACHE_ADDR_W-1:0] base_addr;
  logic [7:0]               word_count;
  logic [7:0]               gap;
  logic                     busy;
  logic                     done;
  logic [15:0]              mismatch_cnt;
  logic                     mem_valid;
  cache_pkg::mem_op_e       mem_op;
  logic [`CACHE_ADDR_W-1:0] mem_addr;
  logic [`CACHE_LINE_W-1:0] mem_wdata;
  logic [`CACHE_LINE_W-1:0] mem_rdata = '0;
  logic                     mem_ready = 1'b0;

  // memory model, 64 lines of 64 bytes
  logic [`CACHE_LINE_W-1:0] mem      [64];
  logic [`CACHE_LINE_W-1:0] init_mem [64];
  integer seed;
  int     delay_left;
  bit     stall_mode;
  int     rd_cnt;
  int     wr_cnt;

  // request held while waiting for ready
  logic                     hold_q;
  logic [`CACHE_ADDR_W-1:0] hold_addr;
  logic [`CACHE_LINE_W-1:0] hold_wdata;
  cache_pkg::mem_op_e       hold_op;

  int data_errs;
  int hs_errs;
  int status_errs;
  int timeout_errs;

  tb_clk_gen u_clk_gen (.o_clk(clk));

  cache_sys_top i_dut (
    .clk(clk), .rst(rst),
    .i_start(start), .i_base_addr(base_addr), .i_word_count(word_count), .i_gap(gap),
    .o_busy(busy), .o_done(done), .o_mismatch_cnt(mismatch_cnt),
    .o_mem_valid(mem_valid), .o_mem_op(mem_op), .o_mem_addr(mem_addr),
    .o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata), .i_mem_ready(mem_ready)
  );

  // expected word k of a run from base
  function automatic logic [63:0] ref_word(input logic [63:0] base, input int k);
    logic [63:0] a;
    a = base + 8 * k;
    ref_word = exer_pkg::PATTERN[k % 8] ^ a;
  endfunction

  function automatic logic [63:0] line_word(input logic [511:0] line, input logic [63:0] a);
    line_word = line[a[5:3]*64 +: 64];
  endfunction

  // memory responder, ready after a random delay
  always @(posedge clk) begin
    if (rst) begin
      mem_ready  <= 1'b0;
      delay_left <= 0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;   // transfer completes on this edge
      if (mem_op == cache_pkg::MEM_WRITE) begin
        mem[mem_addr[11:6]] <= mem_wdata;
        wr_cnt <= wr_cnt + 1;
      end else begin
        rd_cnt <= rd_cnt + 1;
      end
      delay_left <= stall_mode ? 8 + ($random(seed) & 31) : ($random(seed) & 3);
    end else if (mem_valid) begin
      if (delay_left == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_addr[11:6]];
      end else begin
        delay_left <= delay_left - 1;
      end
    end
  end

  // fields must not move while valid waits for ready
  always @(posedge clk) begin
    if (rst) begin
      hold_q <= 1'b0;
    end else begin
      if (hold_q) begin
        assert (mem_valid && mem_op == hold_op) else begin
          $display("memory request dropped or changed opcode before ready");
          hs_errs++;
        end
        assert (mem_addr == hold_addr) else begin
          $display("ERROR o_mem_addr: got %h, expected %h", mem_addr, hold_addr);
          hs_errs++;
        end
        assert (mem_wdata == hold_wdata) else begin
          $display("ERROR o_mem_wdata: got %h, expected %h", mem_wdata, hold_wdata);
          hs_errs++;
        end
      end
      hold_q     <= mem_valid && !mem_ready;
      hold_addr  <= mem_addr;
      hold_wdata <= mem_wdata;
      hold_op    <= mem_op;
    end
  end

  task automatic preload_memory();
    int i;
    int j;
    for (i = 0; i < 64; i++) begin
      for (j = 0; j < 16; j++) begin
        mem[i][j*32 +: 32] = $random(seed);
      end
      init_mem[i] = mem[i];
    end
  endtask

  task automatic report_and_finish();
    $display("errors: data %0d, handshake %0d, status %0d, timeout %0d",
             data_errs, hs_errs, status_errs, timeout_errs);
    if (data_errs + hs_errs + status_errs + timeout_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  // status outputs straight after reset
  task automatic check_reset_values();
    assert (busy === 1'b0) else begin
      $display("ERROR o_busy: got %h, expected %h", busy, 1'b0);
      status_errs++;
    end
    assert (done === 1'b0) else begin
      $display("ERROR o_done: got %h, expected %h", done, 1'b0);
      status_errs++;
    end
    assert (mem_valid === 1'b0) else begin
      $display("ERROR o_mem_valid: got %h, expected %h", mem_valid, 1'b0);
      status_errs++;
    end
    assert (mismatch_cnt === 16'h0) else begin
      $display("ERROR o_mismatch_cnt: got %h, expected %h", mismatch_cnt, 16'h0);
      status_errs++;
    end
  endtask

  task automatic wait_done();
    int cyc;
    cyc = 0;
    @(negedge clk);
    while (done !== 1'b1 && cyc < DONE_LIMIT) begin
      assert (busy === 1'b1) else begin
        $display("ERROR o_busy: got %h, expected %h", busy, 1'b1);
        status_errs++;
      end
      @(negedge clk);
      cyc++;
    end
    if (done !== 1'b1) begin
      $display("timeout: exerciser did not raise done within %0d cycles", DONE_LIMIT);
      timeout_errs++;
    end else begin
      assert (busy === 1'b0) else begin
        $display("ERROR o_busy: got %h, expected %h", busy, 1'b0);
        status_errs++;
      end
    end
  endtask

  task automatic check_memory(input logic [63:0] base, input int count);
    logic [63:0] a;
    int          k;
    for (k = 0; k < count; k++) begin
      a = base + 8 * k;
      assert (line_word(mem[a[11:6]], a) == ref_word(base, k)) else begin
        $display("ERROR o_mem_wdata word at %h: got %h, expected %h",
                 a, line_word(mem[a[11:6]], a), ref_word(base, k));
        data_errs++;
      end
    end
    // tail of the last line was never written, keeps preload
    for (k = count; ((base + 8 * k) & 64'h3f) != 0; k++) begin
      a = base + 8 * k;
      assert (line_word(mem[a[11:6]], a) == line_word(init_mem[a[11:6]], a)) else begin
        $display("ERROR o_mem_wdata word at %h: got %h, expected %h",
                 a, line_word(mem[a[11:6]], a), line_word(init_mem[a[11:6]], a));
        data_errs++;
      end
    end
  endtask

  task automatic run_range(input logic [63:0] base, input int count, input int gap_cyc,
                           input int exp_reads);
    int rd0;
    int wr0;
    if (timeout_errs != 0) return;   // a hung run leaves the DUT busy
    rd0 = rd_cnt;
    wr0 = wr_cnt;
    @(posedge clk);
    start      <= 1'b1;
    base_addr  <= base;
    word_count <= count[7:0];
    gap        <= gap_cyc[7:0];
    @(posedge clk);
    start <= 1'b0;
    wait_done();
    if (timeout_errs != 0) return;
    assert (mismatch_cnt == 16'h0) else begin
      $display("ERROR o_mismatch_cnt: got %h, expected %h", mismatch_cnt, 16'h0);
      data_errs++;
    end
    assert (rd_cnt - rd0 == exp_reads) else begin
      $display("ERROR memory reads: got %h, expected %h", rd_cnt - rd0, exp_reads);
      data_errs++;
    end
    assert (wr_cnt - wr0 == count) else begin
      $display("ERROR memory writes: got %h, expected %h", wr_cnt - wr0, count);
      data_errs++;
    end
    check_memory(base, count);
  endtask

  initial begin
    seed       = 32'hf0300aa6;
    stall_mode = 1'b0;
    rd_cnt     = 0;
    wr_cnt     = 0;
    rst        = 1'b1;
    start      = 1'b0;
    base_addr  = '0;
    word_count = '0;
    gap        = '0;
    preload_memory();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_reset_values();

    run_range(64'h000, 16, 2, 2);     // two fresh lines
    run_range(64'h400, 13, 1, 2);     // partial last line, evicts the first run
    run_range(64'h400, 13, 3, 0);     // same lines again, all hits

    stall_mode = 1'b1;                // long ready stalls from here on
    run_range(64'h800, 128, 0, 16);
    run_range(64'h800, 8, 0, 1);      // line 0x800 was evicted by 0xa00

    report_and_finish();
  end

endmodule

//--- filelist.f
+incdir+src
src/cache_pkg.sv
src/exer_pkg.sv
src/cache_array.sv
src/cache_ctrl_fsm.sv
src/pace_timer.sv
src/cache_exerciser.sv
src/cache_sys_top.sv
verif/tb_clk_gen.sv
verif/tb_cache_sys.sv
